// ==== common/cache_pkg.sv ====
// shared widths, memory message codes and port structs for the data cache
// imported by the RTL blocks and by the testbench

package cache_pkg;

    // byte address covers one 4 KB window
    localparam int ADDR_BITS   = 12;
    localparam int DATA_BITS   = 32;
    localparam int BYTES       = DATA_BITS / 8;

    // one word per line, direct mapped
    localparam int INDEX_BITS  = 4;
    localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - 2;
    localparam int CACHE_DEPTH = 1 << INDEX_BITS;

    // memory word a starts out as a ^ INIT_SALT
    localparam logic [DATA_BITS-1:0] INIT_SALT = 32'h5a3c_96e1;

    typedef enum logic [1:0] {
        NO_REQ   = 2'd0,
        R_REQ    = 2'd1,
        WB_REQ   = 2'd2,
        MEM_RESP = 2'd3
    } mem_msg_t;

    // one request from the core
    typedef struct packed {
        logic                 read;
        logic                 write;
        logic [BYTES-1:0]     byte_en;
        logic [ADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0] data;
    } cpu_req_t;

    // cache to memory
    typedef struct packed {
        mem_msg_t             msg;
        logic [ADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0] data;
    } mem_req_t;

    // memory to cache
    typedef struct packed {
        mem_msg_t             msg;
        logic [DATA_BITS-1:0] data;
    } mem_resp_t;

    // single write into the line store
    // valid low marks an invalidating write from the sweep
    typedef struct packed {
        logic                  en;
        logic [INDEX_BITS-1:0] index;
        logic [TAG_BITS-1:0]   tag;
        logic [DATA_BITS-1:0]  data;
        logic                  dirty;
        logic                  valid;
    } line_write_t;

endpackage

// ==== logic/line_store.sv ====
// tag, data, valid and dirty arrays of the direct-mapped cache
// one registered lookup port and one write port

`timescale 1ns/1ns

module line_store (
    input  logic                             clock,
    input  logic                             rst,
    input  logic [cache_pkg::INDEX_BITS-1:0] lookup_index,
    input  cache_pkg::line_write_t           line_wr,
    output logic [cache_pkg::TAG_BITS-1:0]   line_tag,
    output logic [cache_pkg::DATA_BITS-1:0]  line_data,
    output logic                             line_valid,
    output logic                             line_dirty
);
    import cache_pkg::*;

    logic [TAG_BITS-1:0]  tag_mem   [CACHE_DEPTH];
    logic [DATA_BITS-1:0] data_mem  [CACHE_DEPTH];
    logic                 valid_mem [CACHE_DEPTH];
    logic                 dirty_mem [CACHE_DEPTH];

    // write port
    always_ff @(posedge clock) begin
        if (line_wr.en) begin
            tag_mem[line_wr.index]   <= line_wr.tag;
            data_mem[line_wr.index]  <= line_wr.data;
            valid_mem[line_wr.index] <= line_wr.valid;
            dirty_mem[line_wr.index] <= line_wr.dirty & line_wr.valid;
        end
    end

    // lookup, one cycle after the index
    always_ff @(posedge clock) begin
        line_tag  <= tag_mem[lookup_index];
        line_data <= data_mem[lookup_index];
    end

    // status outputs read as an empty line until the sweep has run
    always_ff @(posedge clock) begin
        if (rst) begin
            line_valid <= 1'b0;
            line_dirty <= 1'b0;
        end else begin
            line_valid <= valid_mem[lookup_index];
            line_dirty <= dirty_mem[lookup_index];
        end
    end

endmodule

// ==== controller/mem_request.sv ====
// outgoing memory message register and refill capture
// holds the message until MEM_RESP, then flags the response for one cycle

`timescale 1ns/1ns

module mem_request (
    input  logic                            clock,
    input  logic                            rst,
    input  logic                            load_read,
    input  logic                            load_wb,
    input  logic [cache_pkg::ADDR_BITS-1:0] msg_addr,
    input  logic [cache_pkg::DATA_BITS-1:0] msg_data,
    output cache_pkg::mem_req_t             mem_req,
    input  cache_pkg::mem_resp_t            mem_resp,
    output logic                            resp_seen,
    output logic [cache_pkg::DATA_BITS-1:0] refill_data
);
    import cache_pkg::*;

    mem_msg_t             msg_q;
    logic [ADDR_BITS-1:0] addr_q;
    logic [DATA_BITS-1:0] data_q;
    logic [DATA_BITS-1:0] refill_q;
    logic                 resp_hit;

    // a response only counts while a message is outstanding
    assign resp_hit = (mem_resp.msg == MEM_RESP) & (msg_q != NO_REQ);

    always_ff @(posedge clock) begin
        if (rst) begin
            msg_q     <= NO_REQ;
            resp_seen <= 1'b0;
        end else begin
            resp_seen <= resp_hit;
            if (load_read) begin
                msg_q <= R_REQ;
            end else if (load_wb) begin
                msg_q <= WB_REQ;
            end else if (resp_hit) begin
                msg_q <= NO_REQ;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load_read || load_wb) begin
            addr_q <= msg_addr;
            // only a write-back carries data
            data_q <= load_wb ? msg_data : '0;
        end
        if (resp_hit && msg_q == R_REQ) begin
            refill_q <= mem_resp.data;
        end
    end

    assign mem_req.msg  = msg_q;
    assign mem_req.addr = addr_q;
    assign mem_req.data = data_q;
    assign refill_data  = refill_q;

endmodule

// ==== controller/cache_controller.sv ====
// cache controller FSM: lookup, hit service, write-back, refill and the
// reset sweep that invalidates every line

`timescale 1ns/1ns

module cache_controller (
    input  logic                              clock,
    input  logic                              rst,
    input  cache_pkg::cpu_req_t               req,
    output logic                              ready,
    output logic                              valid,
    output logic [cache_pkg::DATA_BITS-1:0]   data_out,
    output logic [cache_pkg::INDEX_BITS-1:0]  lookup_index,
    input  logic [cache_pkg::TAG_BITS-1:0]    line_tag,
    input  logic [cache_pkg::DATA_BITS-1:0]   line_data,
    input  logic                              line_valid,
    input  logic                              line_dirty,
    output cache_pkg::line_write_t            line_wr,
    output logic                              load_read,
    output logic                              load_wb,
    output logic [cache_pkg::ADDR_BITS-1:0]   msg_addr,
    output logic [cache_pkg::DATA_BITS-1:0]   msg_data,
    input  logic                              resp_seen,
    input  logic [cache_pkg::DATA_BITS-1:0]   refill_data
);
    import cache_pkg::*;

    // SWEEP first so an uninitialised state reads as not ready
    typedef enum logic [2:0] {
        SWEEP,
        IDLE,
        LOOKUP,
        WRITE_BACK_WAIT,
        READ_WAIT,
        UPDATE
    } state_t;

    state_t                state;
    logic [INDEX_BITS-1:0] sweep_count;
    cpu_req_t              req_q;

    logic                  accept;
    logic [INDEX_BITS-1:0] req_index;
    logic [TAG_BITS-1:0]   req_tag;
    logic                  hit;
    logic                  victim_dirty;
    logic [DATA_BITS-1:0]  merge_base;

    // write bytes land on top of the base word
    function automatic logic [DATA_BITS-1:0] merge_bytes(
        input logic [DATA_BITS-1:0] base,
        input cpu_req_t             r
    );
        logic [DATA_BITS-1:0] m;
        m = base;
        for (int b = 0; b < BYTES; b++) begin
            if (r.write && r.byte_en[b]) begin
                m[8*b +: 8] = r.data[8*b +: 8];
            end
        end
        return m;
    endfunction

    assign accept       = ready & (req.read | req.write);
    assign req_index    = req_q.addr[2 +: INDEX_BITS];
    assign req_tag      = req_q.addr[ADDR_BITS-1 -: TAG_BITS];
    assign hit          = line_valid & (line_tag == req_tag);
    assign victim_dirty = line_valid & line_dirty;

    always_ff @(posedge clock) begin
        if (rst && state != SWEEP) begin
            state       <= SWEEP;
            sweep_count <= '0;
        end else begin
            case (state)
                SWEEP: begin
                    if (sweep_count != INDEX_BITS'(CACHE_DEPTH - 1)) begin
                        sweep_count <= sweep_count + 1'b1;
                    end else if (!rst) begin
                        state <= IDLE;
                    end
                end
                IDLE: begin
                    if (accept) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        state <= IDLE;
                    end else if (victim_dirty) begin
                        state <= WRITE_BACK_WAIT;
                    end else begin
                        state <= READ_WAIT;
                    end
                end
                WRITE_BACK_WAIT: begin
                    if (resp_seen) begin
                        state <= READ_WAIT;
                    end
                end
                READ_WAIT: begin
                    if (resp_seen) begin
                        state <= UPDATE;
                    end
                end
                UPDATE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // request payload
    always_ff @(posedge clock) begin
        if (accept) begin
            req_q <= req;
        end
    end

    assign ready        = (state == IDLE);
    assign lookup_index = (state == IDLE) ? req.addr[2 +: INDEX_BITS] : req_index;

    assign valid    = req_q.read & (((state == LOOKUP) & hit) | (state == UPDATE));
    assign data_out = (state == UPDATE) ? refill_data : line_data;

    assign merge_base = (state == UPDATE) ? refill_data : line_data;

    always_comb begin
        line_wr.en    = (state == SWEEP) | (state == UPDATE) |
                        ((state == LOOKUP) & hit & req_q.write);
        line_wr.index = (state == SWEEP) ? sweep_count : req_index;
        line_wr.tag   = (state == SWEEP) ? '0 : req_tag;
        line_wr.data  = (state == SWEEP) ? '0 : merge_bytes(merge_base, req_q);
        line_wr.dirty = (state != SWEEP) & req_q.write;
        line_wr.valid = (state != SWEEP);
    end

    // dirty victim goes out first, refill follows its response
    assign load_wb   = (state == LOOKUP) & ~hit & victim_dirty;
    assign load_read = ((state == LOOKUP) & ~hit & ~victim_dirty) |
                       ((state == WRITE_BACK_WAIT) & resp_seen);

    assign msg_addr = load_wb ? {line_tag, req_index, 2'b00}
                              : {req_q.addr[ADDR_BITS-1:2], 2'b00};
    assign msg_data = line_data;

endmodule

// ==== logic/cache_top.sv ====
// top level of the write-back data cache
// core port on one side, memory message port on the other

`timescale 1ns/1ns

module cache_top (
    input  logic                            clock,
    input  logic                            rst,
    input  cache_pkg::cpu_req_t             req,
    output logic                            ready,
    output logic                            valid,
    output logic [cache_pkg::DATA_BITS-1:0] data_out,
    output cache_pkg::mem_req_t             mem_req,
    input  cache_pkg::mem_resp_t            mem_resp
);
    import cache_pkg::*;

    logic [INDEX_BITS-1:0] lookup_index;
    logic [TAG_BITS-1:0]   line_tag;
    logic [DATA_BITS-1:0]  line_data;
    logic                  line_valid;
    logic                  line_dirty;
    line_write_t           line_wr;
    logic                  load_read;
    logic                  load_wb;
    logic [ADDR_BITS-1:0]  msg_addr;
    logic [DATA_BITS-1:0]  msg_data;
    logic                  resp_seen;
    logic [DATA_BITS-1:0]  refill_data;

    cache_controller ctrl0 (
        .clock(clock), .rst(rst), .req(req), .ready(ready), .valid(valid),
        .data_out(data_out), .lookup_index(lookup_index), .line_tag(line_tag),
        .line_data(line_data), .line_valid(line_valid), .line_dirty(line_dirty),
        .line_wr(line_wr), .load_read(load_read), .load_wb(load_wb),
        .msg_addr(msg_addr), .msg_data(msg_data), .resp_seen(resp_seen),
        .refill_data(refill_data)
    );

    mem_request mreq0 (
        .clock(clock), .rst(rst), .load_read(load_read), .load_wb(load_wb),
        .msg_addr(msg_addr), .msg_data(msg_data), .mem_req(mem_req),
        .mem_resp(mem_resp), .resp_seen(resp_seen), .refill_data(refill_data)
    );

    line_store store0 (
        .clock(clock), .rst(rst), .lookup_index(lookup_index), .line_wr(line_wr),
        .line_tag(line_tag), .line_data(line_data), .line_valid(line_valid),
        .line_dirty(line_dirty)
    );

endmodule

// ==== verif/cache_chk.sv ====
// bound checker for cache_top: shadow memory for data checks, plus memory
// message and reset protocol assertions

`timescale 1ns/1ns

module cache_chk (
    input  logic                            clock,
    input  logic                            rst,
    input  cache_pkg::cpu_req_t             req,
    input  logic                            ready,
    input  logic                            valid,
    input  logic [cache_pkg::DATA_BITS-1:0] data_out,
    input  cache_pkg::mem_req_t             mem_req,
    input  cache_pkg::mem_resp_t            mem_resp
);
    import cache_pkg::*;

    localparam int WORD_BITS = ADDR_BITS - 2;
    localparam int MEM_WORDS = 1 << WORD_BITS;

    logic [DATA_BITS-1:0] shadow [MEM_WORDS];
    logic [MEM_WORDS-1:0] written;
    logic [MEM_WORDS-1:0] touched;

    logic                 accept;
    logic [WORD_BITS-1:0] req_word;
    logic [WORD_BITS-1:0] wb_word;
    logic [DATA_BITS-1:0] byte_mask;
    logic [DATA_BITS-1:0] base_word;
    logic [DATA_BITS-1:0] merged;
    logic [DATA_BITS-1:0] exp_read;
    logic [DATA_BITS-1:0] wb_expect;

    logic [WORD_BITS-1:0] rd_word;
    logic [WORD_BITS-1:0] prev_word;
    logic                 prev_live;
    logic                 repeat_read;
    logic [WORD_BITS-1:0] pw_word;
    logic                 pw_live;
    logic [DATA_BITS-1:0] pw_value;
    logic                 first_pending;
    logic [WORD_BITS-1:0] first_word;
    logic                 rreq_seen;

    int error_count = 0;

    // untouched memory still holds its start value
    function automatic logic [DATA_BITS-1:0] init_word(input logic [WORD_BITS-1:0] w);
        return DATA_BITS'(w) ^ INIT_SALT;
    endfunction

    assign accept    = ready & (req.read | req.write);
    assign req_word  = req.addr[ADDR_BITS-1:2];
    assign wb_word   = mem_req.addr[ADDR_BITS-1:2];
    assign base_word = written[req_word] ? shadow[req_word] : init_word(req_word);
    assign exp_read  = written[rd_word] ? shadow[rd_word] : init_word(rd_word);
    assign wb_expect = written[wb_word] ? shadow[wb_word] : init_word(wb_word);

    always_comb begin
        for (int b = 0; b < BYTES; b++) begin
            byte_mask[8*b +: 8] = {8{req.byte_en[b]}};
        end
        merged = (base_word & ~byte_mask) | (req.data & byte_mask);
    end

    assign repeat_read = accept & req.read & prev_live & (req_word == prev_word);

    always_ff @(posedge clock) begin
        if (rst) begin
            written       <= '0;
            touched       <= '0;
            prev_live     <= 1'b0;
            pw_live       <= 1'b0;
            first_pending <= 1'b0;
            rreq_seen     <= 1'b0;
        end else begin
            if (ready) begin
                first_pending <= 1'b0;
            end
            if (mem_req.msg == R_REQ && wb_word == first_word) begin
                rreq_seen <= 1'b1;
            end
            if (accept) begin
                prev_word          <= req_word;
                prev_live          <= 1'b1;
                touched[req_word]  <= 1'b1;
                if (!touched[req_word]) begin
                    first_pending <= 1'b1;
                    first_word    <= req_word;
                    rreq_seen     <= 1'b0;
                end
                if (req.read) begin
                    rd_word <= req_word;
                end
                if (req.write) begin
                    shadow[req_word]  <= merged;
                    written[req_word] <= 1'b1;
                    // follow the last partial write so a later read can be checked
                    if (req.byte_en != '1) begin
                        pw_word  <= req_word;
                        pw_live  <= 1'b1;
                        pw_value <= merged;
                    end else if (pw_word == req_word) begin
                        pw_value <= merged;
                    end
                end
            end
        end
    end

    a_read_data: assert property (@(posedge clock) disable iff (rst)
        valid |-> data_out == exp_read)
        else begin
            error_count++;
            $error("Error %0t: read data differs from shadow memory", $time);
        end

    a_partial_merge: assert property (@(posedge clock) disable iff (rst)
        valid && pw_live && rd_word == pw_word |-> data_out == pw_value)
        else begin
            error_count++;
            $error("Error %0t: read after partial write lost the merged bytes", $time);
        end

    a_wb_data: assert property (@(posedge clock) disable iff (rst)
        mem_req.msg == WB_REQ |-> mem_req.data == wb_expect)
        else begin
            error_count++;
            $error("Error %0t: write-back data differs from shadow memory", $time);
        end

    a_repeat_hit: assert property (@(posedge clock) disable iff (rst)
        repeat_read |=> valid && mem_req.msg == NO_REQ)
        else begin
            error_count++;
            $error("repeated read did not hit in one cycle at %0t", $time);
        end

    a_msg_hold: assert property (@(posedge clock) disable iff (rst)
        mem_req.msg != NO_REQ && mem_resp.msg != MEM_RESP |=> $stable(mem_req))
        else begin
            error_count++;
            $error("memory request changed before its response at %0t", $time);
        end

    a_msg_clear: assert property (@(posedge clock) disable iff (rst)
        mem_req.msg != NO_REQ && mem_resp.msg == MEM_RESP |=> mem_req.msg == NO_REQ)
        else begin
            error_count++;
            $error("memory request not cleared after its response at %0t", $time);
        end

    a_reset_ready: assert property (@(posedge clock)
        rst |-> !ready)
        else begin
            error_count++;
            $error("ready was high during reset at %0t", $time);
        end

    a_first_refill: assert property (@(posedge clock) disable iff (rst)
        first_pending && ready |-> rreq_seen)
        else begin
            error_count++;
            $error("first access to an address finished without a refill at %0t", $time);
        end

endmodule

// ==== verif/cache_tb.sv ====
// testbench for cache_top: random core requests over a small address window
// against a memory model with random response delay

`timescale 1ns/1ns

module cache_tb;
    import cache_pkg::*;

    localparam int NUM_REQS       = 600;
    localparam int MAX_REQ_CYCLES = 30;
    localparam int TIMEOUT_CYCLES = NUM_REQS * MAX_REQ_CYCLES + 2000;
    localparam int MEM_WORDS      = 1 << (ADDR_BITS - 2);

    logic                 clock;
    logic                 rst;
    cpu_req_t             req;
    logic                 ready;
    logic                 valid;
    logic [DATA_BITS-1:0] data_out;
    mem_req_t             mem_req;
    mem_resp_t            mem_resp;

    logic [DATA_BITS-1:0] mem [MEM_WORDS];
    logic [ADDR_BITS-1:0] last_addr;

    int seed         = 14741;
    int cycles       = 0;
    int reads        = 0;
    int writes       = 0;
    int resp_count   = 0;
    int wb_count     = 0;
    int check_errors = 0;

    cache_top dut0 (
        .clock(clock), .rst(rst), .req(req), .ready(ready), .valid(valid),
        .data_out(data_out), .mem_req(mem_req), .mem_resp(mem_resp)
    );

    bind cache_top cache_chk chk0 (
        .clock(clock), .rst(rst), .req(req), .ready(ready), .valid(valid),
        .data_out(data_out), .mem_req(mem_req), .mem_resp(mem_resp)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic wait_ready();
        while (!ready) begin
            @(negedge clock);
        end
    endtask

    // single-cycle strobe, taken while ready is high
    task automatic send_request(input cpu_req_t r);
        req = r;
        @(negedge clock);
        req = '0;
    endtask

    // memory model, answers each message after 1 to 8 cycles
    initial begin : memory_model
        int                   delay;
        logic [31:0]          rnd;
        logic [ADDR_BITS-3:0] word;
        for (int w = 0; w < MEM_WORDS; w++) begin
            mem[w] = w ^ INIT_SALT;
        end
        forever begin
            @(negedge clock);
            if (mem_req.msg == R_REQ || mem_req.msg == WB_REQ) begin
                rnd   = $random(seed);
                delay = {29'd0, rnd[2:0]} + 1;
                repeat (delay - 1) @(negedge clock);
                word = mem_req.addr[ADDR_BITS-1:2];
                if (mem_req.msg == WB_REQ) begin
                    mem[word]     = mem_req.data;
                    mem_resp.data = '0;
                    wb_count++;
                end else begin
                    mem_resp.data = mem[word];
                end
                mem_resp.msg = MEM_RESP;
                resp_count++;
                @(negedge clock);
                mem_resp.msg = NO_REQ;
            end
        end
    end

    initial begin : stimulus
        cpu_req_t    r;
        logic [31:0] rnd;
        req      = '0;
        mem_resp = '0;
        rst      = 1'b1;
        repeat (10) @(negedge clock);
        rst = 1'b0;
        for (int i = 0; i < NUM_REQS; i++) begin
            wait_ready();
            rnd = $random(seed);
            r   = '0;
            if (i > 0 && rnd[9:8] == 2'b00) begin
                // same address again, should hit
                r.read = 1'b1;
                r.addr = last_addr;
            end else begin
                r.read    = ~rnd[10];
                r.write   = rnd[10];
                r.addr    = {4'b0000, rnd[5:0], 2'b00};
                r.byte_en = rnd[15:12];
                r.data    = $random(seed);
            end
            if (r.write) begin
                writes++;
            end else begin
                reads++;
            end
            last_addr = r.addr;
            send_request(r);
        end
        wait_ready();
        repeat (4) @(negedge clock);
        check_errors = dut0.chk0.error_count;
        $write("requests %0d (reads %0d, writes %0d), memory responses %0d,",
               reads + writes, reads, writes, resp_count);
        $display(" write-backs %0d, check errors %0d", wb_count, check_errors);
        if (check_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: requests still not done after %0d cycles", TIMEOUT_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== all.f ====
common/cache_pkg.sv
logic/line_store.sv
controller/mem_request.sv
controller/cache_controller.sv
logic/cache_top.sv
verif/cache_chk.sv
verif/cache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module cache_tb -o cache_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

# let the run continue past assertion errors so the testbench reports the counts
output=$(./obj_dir/cache_sim +verilator+error+limit+100000)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
